//--- Makefile
VERILATOR       ?= verilator
TOP             ?= tb_mempool_group
FILELIST        ?= tb.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary -j 0
PASS_TEXT       ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_mempool_group.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the memory group
// Reference memory model, in-order response checker, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_mempool_group
  import group_pkg::*;
;

  localparam int GroupWords = 2 * 64;

  typedef enum logic [1:0] {WRITE, READ, FILL, WAIT_IDLE} op_e;

  typedef struct packed {
    op_e        op;
    tcdm_addr_t addr;
    dma_len_t   len;
    data_t      data;
    strb_t      be;
    logic       stall;
  } row_t;

  logic       clk_i;
  logic       rst_i;
  logic       req_valid_i;
  logic       req_ready_o;
  tcdm_addr_t req_addr_i;
  logic       req_wen_i;
  data_t      req_wdata_i;
  strb_t      req_be_i;
  logic       resp_valid_o;
  logic       resp_ready_i;
  data_t      resp_rdata_o;
  logic       dma_valid_i;
  logic       dma_ready_o;
  tcdm_addr_t dma_start_i;
  dma_len_t   dma_len_i;
  data_t      dma_data_i;
  logic       dma_busy_o;

  row_t  rows[$];
  data_t expected[$];
  data_t model [GroupWords];
  data_t exp_data;
  int    num_rows = 0;
  int    reads_issued = 0;
  int    responses = 0;
  int    seed = 39;
  logic  stall_on = 1'b0;
  logic  busy_seen = 1'b0;

  mempool_group dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic add_row(input op_e op, input int addr, input int len, input data_t data,
                         input strb_t be, input logic stall);
    row_t r;
    r.op    = op;
    r.addr  = tcdm_addr_t'(addr);
    r.len   = dma_len_t'(len);
    r.data  = data;
    r.be    = be;
    r.stall = stall;
    rows.push_back(r);
  endtask

  task automatic check_outputs_quiet();
    assert (!req_ready_o && !dma_ready_o && !resp_valid_o && !dma_busy_o)
    else report_error("handshake or busy output high around reset");
  endtask

  task automatic issue_remote(input row_t r);
    int idx;
    idx         = int'(r.addr);
    req_valid_i = 1'b1;
    req_addr_i  = r.addr;
    req_wen_i   = (r.op == WRITE);
    req_wdata_i = r.data;
    req_be_i    = r.be;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    // Transfer on the coming rising edge
    if (r.op == WRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          model[idx][8*b +: 8] = r.data[8*b +: 8];
        end
      end
    end else begin
      expected.push_back(model[idx]);
      reads_issued++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic issue_fill(input row_t r);
    dma_valid_i = 1'b1;
    dma_start_i = r.addr;
    dma_len_i   = r.len;
    dma_data_i  = r.data;
    @(negedge clk_i);
    while (!dma_ready_o) begin
      @(negedge clk_i);
    end
    // Only words inside the group are written
    for (int a = int'(r.addr); a < int'(r.addr) + int'(r.len); a++) begin
      if (a < GroupWords) begin
        model[a] = r.data;
      end
    end
    @(posedge clk_i);
    #1;
    dma_valid_i = 1'b0;
    busy_seen   = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (!(busy_seen || dma_busy_o)) begin
      @(negedge clk_i);
    end
    while (dma_busy_o) begin
      @(negedge clk_i);
    end
    // Responses leave the queue on falling edges
    while (expected.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    assert (!dma_busy_o && !resp_valid_o) else report_error("group not idle after waiting");
    @(posedge clk_i);
    #1;
  endtask

  // Back-pressure on the response channel
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      resp_ready_i = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  always @(negedge clk_i) begin
    if (dma_busy_o) begin
      busy_seen = 1'b1;
    end
    if (resp_valid_o && resp_ready_i) begin
      assert (expected.size() != 0) else report_error("response with no read outstanding");
      exp_data = expected.pop_front();
      responses++;
      assert (resp_rdata_o === exp_data)
      else report_error($sformatf("read data %h, expected %h", resp_rdata_o, exp_data));
    end
  end

  initial begin
    wait (num_rows != 0);
    repeat (num_rows * 200 + 100) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             num_rows * 200 + 100);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_wen_i    = 1'b0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = 1'b0;
    dma_valid_i  = 1'b0;
    dma_start_i  = '0;
    dma_len_i    = '0;
    dma_data_i   = '0;

    // Full words in both regions
    add_row(WRITE, 5, 0, 32'hA000_0005, 4'hF, 1'b0);
    add_row(WRITE, 70, 0, 32'hB000_0046, 4'hF, 1'b0);
    add_row(READ, 5, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 70, 0, 32'h0, 4'hF, 1'b0);
    // Partial writes
    add_row(WRITE, 6, 0, 32'h1122_3344, 4'hF, 1'b0);
    add_row(WRITE, 6, 0, 32'hAABB_CCDD, 4'b0101, 1'b0);
    add_row(WRITE, 6, 0, 32'h99EE_FF00, 4'b1000, 1'b0);
    add_row(READ, 6, 0, 32'h0, 4'hF, 1'b0);
    add_row(WRITE, 71, 0, 32'h5566_7788, 4'hF, 1'b0);
    add_row(WRITE, 71, 0, 32'h0102_0304, 4'b0110, 1'b0);
    add_row(READ, 71, 0, 32'h0, 4'hF, 1'b0);
    // Fill across the region boundary, neighbors written first
    add_row(WRITE, 59, 0, 32'hC0DE_003B, 4'hF, 1'b0);
    add_row(WRITE, 68, 0, 32'hC0DE_0044, 4'hF, 1'b0);
    add_row(FILL, 60, 8, 32'h5A5A_1234, 4'hF, 1'b0);
    add_row(WAIT_IDLE, 0, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 59, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 60, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 63, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 64, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 67, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 68, 0, 32'h0, 4'hF, 1'b0);
    // Back-to-back reads to alternating regions under stalls
    add_row(READ, 5, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 70, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 6, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 71, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 60, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 64, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 59, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 68, 0, 32'h0, 4'hF, 1'b1);
    add_row(WAIT_IDLE, 0, 0, 32'h0, 4'hF, 1'b0);
    // Remote traffic on region 0 while a fill runs there
    add_row(WRITE, 50, 0, 32'h3232_3232, 4'hF, 1'b0);
    add_row(FILL, 10, 40, 32'h0F0F_5555, 4'hF, 1'b0);
    add_row(WRITE, 55, 0, 32'hDEAD_0037, 4'hF, 1'b1);
    add_row(WRITE, 2, 0, 32'hBEEF_0002, 4'hF, 1'b1);
    add_row(WRITE, 50, 0, 32'hFACE_0032, 4'b0011, 1'b1);
    add_row(READ, 55, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 2, 0, 32'h0, 4'hF, 1'b1);
    add_row(READ, 5, 0, 32'h0, 4'hF, 1'b1);
    add_row(WRITE, 70, 0, 32'h7070_7070, 4'hF, 1'b1);
    add_row(WAIT_IDLE, 0, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 10, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 30, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 49, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 50, 0, 32'h0, 4'hF, 1'b0);
    add_row(READ, 70, 0, 32'h0, 4'hF, 1'b0);
    add_row(WAIT_IDLE, 0, 0, 32'h0, 4'hF, 1'b0);
    num_rows = rows.size();

    repeat (8) begin
      @(negedge clk_i);
      check_outputs_quiet();
    end
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_outputs_quiet();
    @(posedge clk_i);
    #1;

    for (int i = 0; i < num_rows; i++) begin
      stall_on = rows[i].stall;
      case (rows[i].op)
        WRITE, READ: issue_remote(rows[i]);
        FILL:        issue_fill(rows[i]);
        default:     wait_idle();
      endcase
    end

    assert (reads_issued == responses && expected.size() == 0)
    else report_error($sformatf("%0d reads but %0d responses", reads_issued, responses));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_mempool_group

//--- source/bank_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter between remote port and DMA backend
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bank_arbiter
  import group_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       rmt_valid_i,
  output logic       rmt_ready_o,
  input  tcdm_addr_t rmt_addr_i,
  input  logic       rmt_wen_i,
  input  data_t      rmt_wdata_i,
  input  strb_t      rmt_be_i,
  input  logic       dma_valid_i,
  output logic       dma_ready_o,
  input  tcdm_addr_t dma_addr_i,
  input  data_t      dma_data_i,
  output logic       bank_valid_o,
  input  logic       bank_ready_i,
  output tcdm_addr_t bank_addr_o,
  output logic       bank_wen_o,
  output data_t      bank_wdata_o,
  output strb_t      bank_be_o,
  output logic       bank_rmt_o
);

  // Set when the DMA wins the next tie
  logic prio_q;
  logic grant_rmt;

  assign grant_rmt = rmt_valid_i && !(dma_valid_i && prio_q);

  assign bank_valid_o = rmt_valid_i || dma_valid_i;
  assign bank_rmt_o   = grant_rmt;
  assign bank_addr_o  = grant_rmt ? rmt_addr_i : dma_addr_i;
  assign bank_wen_o   = grant_rmt ? rmt_wen_i : 1'b1;
  assign bank_wdata_o = grant_rmt ? rmt_wdata_i : dma_data_i;
  assign bank_be_o    = grant_rmt ? rmt_be_i : '1;

  assign rmt_ready_o = grant_rmt && bank_ready_i;
  assign dma_ready_o = dma_valid_i && !grant_rmt && bank_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q <= 1'b0;
    end else if (rmt_valid_i && dma_valid_i && bank_ready_i) begin
      prio_q <= !prio_q;
    end
  end

endmodule : bank_arbiter

//--- source/dma_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA backend, one word write per cycle over one sub-group piece
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_backend
  import group_pkg::*;
#(
  parameter int unsigned WordsPerBank = 64
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       start_i,
  input  tcdm_addr_t piece_start_i,
  input  dma_len_t   piece_len_i,
  input  data_t      piece_data_i,
  output logic       wr_valid_o,
  input  logic       wr_ready_i,
  output tcdm_addr_t wr_addr_o,
  output data_t      wr_data_o,
  output logic       done_o
);

  // A piece never exceeds one bank
  typedef logic [$clog2(WordsPerBank):0] cnt_t;

  dma_state_e state_q;
  tcdm_addr_t addr_q;
  cnt_t       remain_q;
  data_t      data_q;
  logic       wr_fire;
  logic       last;

  assign wr_valid_o = (state_q == BUSY);
  assign wr_addr_o  = addr_q;
  assign wr_data_o  = data_q;
  assign wr_fire    = wr_valid_o && wr_ready_i;
  assign last       = (remain_q == cnt_t'(1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= wr_fire && last;
      if (start_i) begin
        state_q <= BUSY;
      end else if (wr_fire && last) begin
        state_q <= IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= piece_start_i;
      remain_q <= cnt_t'(piece_len_i);
      data_q   <= piece_data_i;
    end else if (wr_fire) begin
      addr_q   <= addr_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

endmodule : dma_backend

//--- source/dma_midend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA midend, splits one fill burst over the sub-group regions
// and waits for every started backend to finish
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_midend
  import group_pkg::*;
#(
  parameter int unsigned NumSubGroups = 2,
  parameter int unsigned WordsPerBank = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  tcdm_addr_t                    req_start_i,
  input  dma_len_t                      req_len_i,
  input  data_t                         req_data_i,
  output logic       [NumSubGroups-1:0] start_o,
  output tcdm_addr_t [NumSubGroups-1:0] piece_start_o,
  output dma_len_t   [NumSubGroups-1:0] piece_len_o,
  output data_t                         piece_data_o,
  input  logic       [NumSubGroups-1:0] done_i,
  output logic                          busy_o
);

  // One extra bit so the burst end never wraps
  typedef logic [16:0] span_t;

  dma_state_e                    state_q;
  dma_state_e                    state_d;
  logic       [NumSubGroups-1:0] pending_q;
  logic       [NumSubGroups-1:0] pending_d;
  logic       [NumSubGroups-1:0] start_d;
  logic       [NumSubGroups-1:0] hit;
  tcdm_addr_t [NumSubGroups-1:0] piece_start;
  dma_len_t   [NumSubGroups-1:0] piece_len;
  span_t                         burst_lo;
  span_t                         burst_hi;

  assign burst_lo = {1'b0, req_start_i};
  assign burst_hi = {1'b0, req_start_i} + {1'b0, req_len_i};

  for (genvar k = 0; k < NumSubGroups; k++) begin : gen_piece
    localparam span_t RegionLo = span_t'(k * WordsPerBank);
    localparam span_t RegionHi = span_t'((k + 1) * WordsPerBank);
    span_t lo;
    span_t hi;
    assign lo             = (burst_lo > RegionLo) ? burst_lo : RegionLo;
    assign hi             = (burst_hi < RegionHi) ? burst_hi : RegionHi;
    assign hit[k]         = lo < hi;
    assign piece_start[k] = tcdm_addr_t'(lo);
    assign piece_len[k]   = dma_len_t'(hi - lo);
  end : gen_piece

  assign req_ready_o = (state_q == IDLE);
  assign busy_o      = (state_q == BUSY);

  always_comb begin
    state_d   = state_q;
    pending_d = pending_q;
    start_d   = '0;
    unique case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d   = BUSY;
          pending_d = hit;
          start_d   = hit;
        end
      end
      BUSY: begin
        pending_d = pending_q & ~done_i;
        // An empty burst leaves here after one cycle
        if (pending_d == '0) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      pending_q <= '0;
      start_o   <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
      start_o   <= start_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      piece_start_o <= piece_start;
      piece_len_o   <= piece_len;
      piece_data_o  <= req_data_i;
    end
  end

endmodule : dma_midend

//--- source/dma_req_register.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry spill register on the DMA request path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_req_register
  import group_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  tcdm_addr_t in_start_i,
  input  dma_len_t   in_len_i,
  input  data_t      in_data_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output tcdm_addr_t out_start_o,
  output dma_len_t   out_len_o,
  output data_t      out_data_o
);

  localparam int unsigned PayloadW = $bits(tcdm_addr_t) + $bits(dma_len_t) + $bits(data_t);

  logic [PayloadW-1:0] a_q;
  logic [PayloadW-1:0] b_q;
  logic                a_full_q;
  logic                b_full_q;
  logic                a_full_d;
  logic                b_full_d;
  logic                ready_q;
  logic                a_fill;
  logic                a_drain;
  logic                b_fill;
  logic                b_drain;

  assign a_fill  = in_valid_i && ready_q;
  // Slot A empties into the output or into slot B
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !out_ready_i;
  assign b_drain = b_full_q && out_ready_i;

  assign a_full_d = a_fill || (a_full_q && !a_drain);
  assign b_full_d = b_fill || (b_full_q && !b_drain);

  assign in_ready_o  = ready_q;
  assign out_valid_o = a_full_q || b_full_q;
  assign {out_start_o, out_len_o, out_data_o} = b_full_q ? b_q : a_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      ready_q  <= !(a_full_d && b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_q <= {in_start_i, in_len_i, in_data_i};
    end
    if (b_fill) begin
      b_q <= a_q;
    end
  end

endmodule : dma_req_register

//--- source/group_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared word, address and length types of the memory group
// DMA state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package group_pkg;

  // Data word and its byte enables
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Word address over the whole group, region index in the upper bits
  typedef logic [15:0] tcdm_addr_t;

  // Fill length in words
  typedef logic [15:0] dma_len_t;

  typedef enum logic {
    IDLE,
    BUSY
  } dma_state_e;

endpackage : group_pkg

//--- source/mempool_group.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory group top level, remote router and DMA path
// Per sub-group backend, arbiter and TCDM bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mempool_group
  import group_pkg::*;
#(
  parameter int unsigned NumSubGroups  = 2,
  parameter int unsigned WordsPerBank  = 64,
  parameter int unsigned RespFifoDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_i,
  // Remote port
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  tcdm_addr_t req_addr_i,
  input  logic       req_wen_i,
  input  data_t      req_wdata_i,
  input  strb_t      req_be_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output data_t      resp_rdata_o,
  // DMA fill request
  input  logic       dma_valid_i,
  output logic       dma_ready_o,
  input  tcdm_addr_t dma_start_i,
  input  dma_len_t   dma_len_i,
  input  data_t      dma_data_i,
  output logic       dma_busy_o
);

  logic                          cut_valid;
  logic                          cut_ready;
  tcdm_addr_t                    cut_start;
  dma_len_t                      cut_len;
  data_t                         cut_data;
  logic       [NumSubGroups-1:0] piece_go;
  tcdm_addr_t [NumSubGroups-1:0] piece_start;
  dma_len_t   [NumSubGroups-1:0] piece_len;
  data_t                         piece_data;
  logic       [NumSubGroups-1:0] piece_done;

  logic       [NumSubGroups-1:0] rmt_valid;
  logic       [NumSubGroups-1:0] rmt_ready;
  tcdm_addr_t [NumSubGroups-1:0] rmt_addr;
  logic       [NumSubGroups-1:0] rmt_wen;
  data_t      [NumSubGroups-1:0] rmt_wdata;
  strb_t      [NumSubGroups-1:0] rmt_be;
  logic       [NumSubGroups-1:0] rsp_valid;
  data_t      [NumSubGroups-1:0] rsp_rdata;
  logic       [NumSubGroups-1:0] rsp_ready;

  dma_req_register i_dma_req_register (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (dma_valid_i),
    .in_ready_o (dma_ready_o),
    .in_start_i (dma_start_i),
    .in_len_i   (dma_len_i),
    .in_data_i  (dma_data_i),
    .out_valid_o(cut_valid),
    .out_ready_i(cut_ready),
    .out_start_o(cut_start),
    .out_len_o  (cut_len),
    .out_data_o (cut_data)
  );

  dma_midend #(
    .NumSubGroups(NumSubGroups),
    .WordsPerBank(WordsPerBank)
  ) i_dma_midend (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (cut_valid),
    .req_ready_o  (cut_ready),
    .req_start_i  (cut_start),
    .req_len_i    (cut_len),
    .req_data_i   (cut_data),
    .start_o      (piece_go),
    .piece_start_o(piece_start),
    .piece_len_o  (piece_len),
    .piece_data_o (piece_data),
    .done_i       (piece_done),
    .busy_o       (dma_busy_o)
  );

  remote_router #(
    .NumSubGroups (NumSubGroups),
    .WordsPerBank (WordsPerBank),
    .RespFifoDepth(RespFifoDepth)
  ) i_remote_router (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_wen_i   (req_wen_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_rdata_o(resp_rdata_o),
    .rmt_valid_o (rmt_valid),
    .rmt_ready_i (rmt_ready),
    .rmt_addr_o  (rmt_addr),
    .rmt_wen_o   (rmt_wen),
    .rmt_wdata_o (rmt_wdata),
    .rmt_be_o    (rmt_be),
    .rsp_valid_i (rsp_valid),
    .rsp_rdata_i (rsp_rdata),
    .rsp_ready_o (rsp_ready)
  );

  for (genvar sg = 0; sg < NumSubGroups; sg++) begin : gen_sub_groups
    logic       dma_wr_valid;
    logic       dma_wr_ready;
    tcdm_addr_t dma_wr_addr;
    data_t      dma_wr_data;
    logic       bank_valid;
    logic       bank_ready;
    tcdm_addr_t bank_addr;
    logic       bank_wen;
    data_t      bank_wdata;
    strb_t      bank_be;
    logic       bank_rmt;

    dma_backend #(
      .WordsPerBank(WordsPerBank)
    ) i_dma_backend (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (piece_go[sg]),
      .piece_start_i(piece_start[sg]),
      .piece_len_i  (piece_len[sg]),
      .piece_data_i (piece_data),
      .wr_valid_o   (dma_wr_valid),
      .wr_ready_i   (dma_wr_ready),
      .wr_addr_o    (dma_wr_addr),
      .wr_data_o    (dma_wr_data),
      .done_o       (piece_done[sg])
    );

    bank_arbiter i_bank_arbiter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rmt_valid_i (rmt_valid[sg]),
      .rmt_ready_o (rmt_ready[sg]),
      .rmt_addr_i  (rmt_addr[sg]),
      .rmt_wen_i   (rmt_wen[sg]),
      .rmt_wdata_i (rmt_wdata[sg]),
      .rmt_be_i    (rmt_be[sg]),
      .dma_valid_i (dma_wr_valid),
      .dma_ready_o (dma_wr_ready),
      .dma_addr_i  (dma_wr_addr),
      .dma_data_i  (dma_wr_data),
      .bank_valid_o(bank_valid),
      .bank_ready_i(bank_ready),
      .bank_addr_o (bank_addr),
      .bank_wen_o  (bank_wen),
      .bank_wdata_o(bank_wdata),
      .bank_be_o   (bank_be),
      .bank_rmt_o  (bank_rmt)
    );

    tcdm_bank #(
      .WordsPerBank(WordsPerBank)
    ) i_tcdm_bank (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bank_valid_i(bank_valid),
      .bank_ready_o(bank_ready),
      .bank_addr_i (bank_addr),
      .bank_wen_i  (bank_wen),
      .bank_wdata_i(bank_wdata),
      .bank_be_i   (bank_be),
      .bank_rmt_i  (bank_rmt),
      .rsp_valid_o (rsp_valid[sg]),
      .rsp_ready_i (rsp_ready[sg]),
      .rsp_rdata_o (rsp_rdata[sg])
    );
  end : gen_sub_groups

endmodule : mempool_group

//--- source/remote_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Remote request router with in-order read response return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module remote_router
  import group_pkg::*;
#(
  parameter int unsigned NumSubGroups  = 2,
  parameter int unsigned WordsPerBank  = 64,
  parameter int unsigned RespFifoDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  tcdm_addr_t                    req_addr_i,
  input  logic                          req_wen_i,
  input  data_t                         req_wdata_i,
  input  strb_t                         req_be_i,
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output data_t                         resp_rdata_o,
  output logic       [NumSubGroups-1:0] rmt_valid_o,
  input  logic       [NumSubGroups-1:0] rmt_ready_i,
  output tcdm_addr_t [NumSubGroups-1:0] rmt_addr_o,
  output logic       [NumSubGroups-1:0] rmt_wen_o,
  output data_t      [NumSubGroups-1:0] rmt_wdata_o,
  output strb_t      [NumSubGroups-1:0] rmt_be_o,
  input  logic       [NumSubGroups-1:0] rsp_valid_i,
  input  data_t      [NumSubGroups-1:0] rsp_rdata_i,
  output logic       [NumSubGroups-1:0] rsp_ready_o
);

  localparam int unsigned IdxW = $clog2(WordsPerBank);
  localparam int unsigned SgW  = $clog2(NumSubGroups);
  localparam int unsigned PtrW = $clog2(RespFifoDepth);

  typedef logic [SgW-1:0]  sg_idx_t;
  typedef logic [PtrW-1:0] ptr_t;

  // Sub-group of every read still waiting for its response
  sg_idx_t       order_q [RespFifoDepth];
  ptr_t          wr_ptr_q;
  ptr_t          rd_ptr_q;
  logic [PtrW:0] count_q;
  logic          active_q;
  sg_idx_t       sel;
  sg_idx_t       head;
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  assign sel   = req_addr_i[IdxW +: SgW];
  assign full  = (count_q == (PtrW + 1)'(RespFifoDepth));
  assign empty = (count_q == '0);
  assign head  = order_q[rd_ptr_q];

  assign req_ready_o  = active_q && !full && rmt_ready_i[sel];
  assign push         = req_valid_i && req_ready_o && !req_wen_i;
  assign resp_valid_o = !empty && rsp_valid_i[head];
  assign resp_rdata_o = rsp_rdata_i[head];
  assign pop          = resp_valid_o && resp_ready_i;

  for (genvar k = 0; k < NumSubGroups; k++) begin : gen_port
    assign rmt_valid_o[k] = req_valid_i && active_q && !full && (sel == sg_idx_t'(k));
    assign rmt_addr_o[k]  = req_addr_i;
    assign rmt_wen_o[k]   = req_wen_i;
    assign rmt_wdata_o[k] = req_wdata_i;
    assign rmt_be_o[k]    = req_be_i;
    // Only the oldest outstanding read may return
    assign rsp_ready_o[k] = !empty && (head == sg_idx_t'(k)) && resp_ready_i;
  end : gen_port

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      active_q <= 1'b1;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(RespFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(RespFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= sel;
    end
  end

endmodule : remote_router

//--- source/tcdm_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory bank with byte-masked writes and held read response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tcdm_bank
  import group_pkg::*;
#(
  parameter int unsigned WordsPerBank = 64
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       bank_valid_i,
  output logic       bank_ready_o,
  input  tcdm_addr_t bank_addr_i,
  input  logic       bank_wen_i,
  input  data_t      bank_wdata_i,
  input  strb_t      bank_be_i,
  input  logic       bank_rmt_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output data_t      rsp_rdata_o
);

  localparam int unsigned IdxW = $clog2(WordsPerBank);

  data_t            mem_q [WordsPerBank];
  logic  [IdxW-1:0] idx;
  logic             accept;
  logic             rd_accept;

  assign idx          = bank_addr_i[IdxW-1:0];
  assign bank_ready_o = !rsp_valid_o || rsp_ready_i;
  assign accept       = bank_valid_i && bank_ready_o;
  assign rd_accept    = accept && bank_rmt_i && !bank_wen_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else if (rd_accept) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && bank_wen_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bank_be_i[b]) begin
          mem_q[idx][8*b +: 8] <= bank_wdata_i[8*b +: 8];
        end
      end
    end
    if (rd_accept) begin
      rsp_rdata_o <= mem_q[idx];
    end
  end

endmodule : tcdm_bank

//--- tb.f
source/group_pkg.sv
source/dma_req_register.sv
source/dma_midend.sv
source/dma_backend.sv
source/remote_router.sv
source/bank_arbiter.sv
source/tcdm_bank.sv
source/mempool_group.sv
bench/tb_mempool_group.sv
